/* Bender.yml */
package:
  name: cpu

sources:
  - common/cpu_pkg.sv
  - common/hazard_if.sv
  - logic/fetch_stage.sv
  - logic/program_memory.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/mem_stage.sv
  - logic/hazard_unit.sv
  - logic/cpu.sv
  - target: test
    files:
      - bench/cpu_sva.sv
      - bench/cpu_tb.sv

/* bench/cpu_sva.sv */
`timescale 1ns/1ns

module cpu_sva (
    input logic              clk,
    input logic              reset_n,
    input logic              if_id_write,
    input logic              id_ex_flush,
    input cpu_pkg::forward_e forward_a,
    input cpu_pkg::forward_e forward_b,
    input logic [4:0]        rs1,
    input logic [4:0]        rs2,
    input logic              branch_taken
);
    import cpu_pkg::*;

    int fail_count = 0;

    // stall and bubble come together for exactly one cycle
    flush_with_stall: assert property (@(posedge clk) disable iff (!reset_n)
        id_ex_flush |-> !if_id_write ##1 (if_id_write && !id_ex_flush))
        else begin
            $error("load-use stall did not end after one bubble");
            fail_count++;
        end

    fwd_a_not_x0: assert property (@(posedge clk) disable iff (!reset_n)
        forward_a != FWD_NONE |-> rs1 != 5'd0)
        else begin
            $error("operand a forwarded for x0");
            fail_count++;
        end

    fwd_b_not_x0: assert property (@(posedge clk) disable iff (!reset_n)
        forward_b != FWD_NONE |-> rs2 != 5'd0)
        else begin
            $error("operand b forwarded for x0");
            fail_count++;
        end

    no_branch_in_reset: assert property (@(posedge clk)
        !reset_n && $past(!reset_n) |-> !branch_taken)
        else begin
            $error("branch taken while in reset");
            fail_count++;
        end

endmodule

/* bench/cpu_tb.sv */
`timescale 1ns/1ns

module cpu_tb;

    localparam int N          = 120;
    localparam int LAST       = N - 1;    // self-loop slot
    localparam int PAD        = 4;        // nops past the end of the program
    localparam int PERIOD     = 40;
    localparam int WATCHDOG   = 10 * N + 100;
    localparam logic [31:0] NOP = 32'h0000_0013;

    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_AND  = 2;
    localparam int K_OR   = 3;
    localparam int K_XOR  = 4;
    localparam int K_ADDI = 5;
    localparam int K_LW   = 6;
    localparam int K_SW   = 7;
    localparam int K_BR   = 8;

    logic        clk;
    logic        reset_n;
    logic        prog_write;
    logic [7:0]  prog_address;
    logic [31:0] prog_data;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    int          kind [N];
    logic [4:0]  rd_a [N];
    logic [4:0]  rs1_a [N];
    logic [4:0]  rs2_a [N];
    logic [31:0] imm_a [N];
    logic        ne_a [N];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    logic [31:0] rng_state = 32'h94e81b69;
    int          seen = 0;
    int          total = 0;

    cpu #(.PROG_WORDS(256), .DATA_WORDS(256)) cpu_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .prog_write   (prog_write),
        .prog_address (prog_address),
        .prog_data    (prog_data),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

    bind hazard_unit cpu_sva sva_inst (
        .clk          (cpu_tb.clk),
        .reset_n      (cpu_tb.reset_n),
        .if_id_write  (hz.if_id_write),
        .id_ex_flush  (hz.id_ex_flush),
        .forward_a    (forward_a),
        .forward_b    (forward_b),
        .rs1          (id_ex.reg_rs1_id),
        .rs2          (id_ex.reg_rs2_id),
        .branch_taken (cpu_tb.cpu_inst.hz.branch_taken)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic make_program();
        logic [31:0] r;
        logic [31:0] s;
        for (int i = 0; i < LAST; i++) begin
            r = next_rand();
            s = next_rand();
            kind[i]  = int'(r % 9);
            rd_a[i]  = {2'b00, s[2:0]};   // x0..x7 only
            rs1_a[i] = {2'b00, s[10:8]};
            rs2_a[i] = {2'b00, s[18:16]};
            ne_a[i]  = r[8];
            imm_a[i] = {{20{r[31]}}, r[31:20]};
            if (i > 0 && kind[i-1] == K_LW) begin
                rs1_a[i] = rd_a[i-1];  // load-use
            end
            if (kind[i] == K_LW || kind[i] == K_SW) begin
                rs1_a[i] = 5'd0;
                imm_a[i] = {26'd0, r[23:20], 2'b00};
            end
            if (kind[i] == K_BR) begin
                imm_a[i] = (1 + int'(r[22:20]) % (LAST - i)) * 4;  // forward only
            end
        end
        kind[LAST]  = K_BR;  // beq x0, x0, 0
        rd_a[LAST]  = 5'd0;
        rs1_a[LAST] = 5'd0;
        rs2_a[LAST] = 5'd0;
        imm_a[LAST] = 32'd0;
        ne_a[LAST]  = 1'b0;
    endtask

    function automatic logic [31:0] encode(input int idx);
        logic [4:0]  rd;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [31:0] im;
        logic [31:0] w;
        rd = rd_a[idx];
        s1 = rs1_a[idx];
        s2 = rs2_a[idx];
        im = imm_a[idx];
        case (kind[idx])
            K_ADD:   w = {7'b0000000, s2, s1, 3'b000, rd, 7'b0110011};
            K_SUB:   w = {7'b0100000, s2, s1, 3'b000, rd, 7'b0110011};
            K_AND:   w = {7'b0000000, s2, s1, 3'b111, rd, 7'b0110011};
            K_OR:    w = {7'b0000000, s2, s1, 3'b110, rd, 7'b0110011};
            K_XOR:   w = {7'b0000000, s2, s1, 3'b100, rd, 7'b0110011};
            K_ADDI:  w = {im[11:0], s1, 3'b000, rd, 7'b0010011};
            K_LW:    w = {im[11:0], s1, 3'b010, rd, 7'b0000011};
            K_SW:    w = {im[11:5], s2, s1, 3'b010, im[4:0], 7'b0100011};
            default: w = {im[12], im[10:5], s2, s1, 2'b00, ne_a[idx], im[4:1], im[11],
                          7'b1100011};
        endcase
        return w;
    endfunction

    // sequential reference, one instruction at a time
    task automatic run_model();
        logic [31:0] x [32];
        logic [31:0] dmem [16];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        int          pc;
        int          next;
        foreach (x[j]) x[j] = '0;
        foreach (dmem[j]) dmem[j] = '0;
        pc = 0;
        while (pc != LAST) begin
            a    = x[rs1_a[pc]];
            b    = x[rs2_a[pc]];
            res  = '0;
            next = pc + 1;
            case (kind[pc])
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_ADDI: res = a + imm_a[pc];
                K_LW:   res = dmem[imm_a[pc][5:2]];
                K_SW:   dmem[imm_a[pc][5:2]] = b;
                default: begin
                    if ((a == b) != ne_a[pc]) next = pc + int'(imm_a[pc] >> 2);
                end
            endcase
            if (kind[pc] <= K_LW && rd_a[pc] != 5'd0) begin
                x[rd_a[pc]] = res;
                exp_rd.push_back(rd_a[pc]);
                exp_data.push_back(res);
            end
            pc = next;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG * PERIOD);
        $display("Timeout: the trace port did not deliver every expected register write in time");
        $display("Something failed");
        $fatal(1);
    end

    // trace monitor, samples on the falling edge
    initial begin
        forever begin
            @(negedge clk);
            check_value("cpu_sva fail_count",
                        cpu_inst.hazard_inst.sva_inst.fail_count, 32'd0);
            if (!reset_n) begin
                check_value("wb_valid", wb_valid, 32'd0);
            end else if (wb_valid) begin
                if (exp_rd.size() == 0) begin
                    $display("Error at %0t ns: register write to x%0d beyond the model's trace",
                             $time, wb_rd);
                    $display("Something failed");
                    $fatal(1);
                end
                check_value("wb_rd", wb_rd, exp_rd.pop_front());
                check_value("wb_data", wb_data, exp_data.pop_front());
                seen++;
            end
        end
    end

    initial begin
        reset_n      = 1'b0;
        prog_write   = 1'b0;
        prog_address = '0;
        prog_data    = '0;
        make_program();
        run_model();
        total = exp_rd.size();
        for (int i = 0; i < N + PAD; i++) begin
            @(negedge clk);
            prog_write   = 1'b1;
            prog_address = 8'(i);
            prog_data    = (i < N) ? encode(i) : NOP;
        end
        @(negedge clk);
        prog_write = 1'b0;
        repeat (2) @(negedge clk);
        reset_n = 1'b1;
        while (seen < total) @(negedge clk);
        repeat (50) @(negedge clk);  // self-loop must stay quiet
        if (cpu_inst.hazard_inst.sva_inst.fail_count != 0) begin
            $display("A bound assertion on the pipeline control failed near the end of the run");
            $display("Something failed");
            $fatal(1);
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

/* common/cpu_pkg.sv */
package cpu_pkg;

    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_I      = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_R      = 7'b0110011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } forward_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instruction_type;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src;   // operand b from immediate
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    is_branch;
        logic    branch_ne;
    } control_type;

    typedef struct packed {
        logic [31:0]     pc;
        instruction_type instruction;
    } if_id_type;

    typedef struct packed {
        logic [4:0]  reg_rs1_id;
        logic [4:0]  reg_rs2_id;
        logic [4:0]  reg_rd_id;
        logic [31:0] data1;
        logic [31:0] data2;
        logic [31:0] immediate_data;
        logic [31:0] pc;
        control_type control;
    } id_ex_type;

    typedef struct packed {
        logic [4:0]  reg_rd_id;
        logic [31:0] alu_data;
        logic [31:0] memory_data;  // store data
        control_type control;
    } ex_mem_type;

    typedef struct packed {
        logic [4:0]  reg_rd_id;
        logic [31:0] alu_data;
        logic [31:0] memory_data;  // load result
        control_type control;
    } mem_wb_type;

    localparam instruction_type NOP_INSTRUCTION = 32'h0000_0013;  // addi x0, x0, 0

endpackage

/* common/hazard_if.sv */
`timescale 1ns/1ns

interface hazard_if;
    logic        pc_write;
    logic        if_id_write;
    logic        id_ex_flush;
    logic        branch_taken;
    logic [31:0] branch_target;

    modport hazard (
        output pc_write, if_id_write, id_ex_flush
    );

    modport execute (
        output branch_taken, branch_target
    );

    modport pipeline (
        input pc_write, if_id_write, id_ex_flush, branch_taken, branch_target
    );
endinterface

/* logic/cpu.sv */
`timescale 1ns/1ns

module cpu #(
    parameter int PROG_WORDS = 256,
    parameter int DATA_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          prog_write,
    input  logic [$clog2(PROG_WORDS)-1:0] prog_address,
    input  logic [31:0]                   prog_data,
    output logic                          wb_valid,
    output logic [4:0]                    wb_rd,
    output logic [31:0]                   wb_data
);
    import cpu_pkg::*;

    hazard_if hz ();

    logic [31:0]     fetch_pc;
    instruction_type fetch_instruction;

    logic [4:0]  decode_rd_id;
    logic [31:0] decode_data1;
    logic [31:0] decode_data2;
    logic [31:0] decode_immediate;
    control_type decode_control;

    forward_e    forward_a;
    forward_e    forward_b;
    logic [31:0] execute_alu_data;
    logic [31:0] execute_memory_data;
    logic [31:0] memory_read_data;
    logic [31:0] wb_result;

    if_id_type  if_id;
    id_ex_type  id_ex;
    ex_mem_type ex_mem;
    mem_wb_type mem_wb;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            if_id.pc          <= '0;
            if_id.instruction <= NOP_INSTRUCTION;
        end else if (hz.branch_taken) begin
            if_id.instruction <= NOP_INSTRUCTION;  // wrong-path fetch
        end else if (hz.if_id_write) begin
            if_id.pc          <= fetch_pc;
            if_id.instruction <= fetch_instruction;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n || hz.id_ex_flush || hz.branch_taken) begin
            id_ex <= '0;  // bubble
        end else begin
            id_ex.reg_rs1_id     <= if_id.instruction.rs1;
            id_ex.reg_rs2_id     <= if_id.instruction.rs2;
            id_ex.reg_rd_id      <= decode_rd_id;
            id_ex.data1          <= decode_data1;
            id_ex.data2          <= decode_data2;
            id_ex.immediate_data <= decode_immediate;
            id_ex.pc             <= if_id.pc;
            id_ex.control        <= decode_control;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ex_mem <= '0;
            mem_wb <= '0;
        end else begin
            ex_mem.reg_rd_id   <= id_ex.reg_rd_id;
            ex_mem.alu_data    <= execute_alu_data;
            ex_mem.memory_data <= execute_memory_data;
            ex_mem.control     <= id_ex.control;
            mem_wb.reg_rd_id   <= ex_mem.reg_rd_id;
            mem_wb.alu_data    <= ex_mem.alu_data;
            mem_wb.memory_data <= memory_read_data;
            mem_wb.control     <= ex_mem.control;
        end
    end

    fetch_stage fetch_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .hz      (hz.pipeline),
        .pc      (fetch_pc)
    );

    program_memory #(.PROG_WORDS(PROG_WORDS)) program_memory_inst (
        .clk           (clk),
        .byte_address  (fetch_pc),
        .write_enable  (prog_write),
        .write_address (prog_address),
        .write_data    (prog_data),
        .read_data     (fetch_instruction)
    );

    decode_stage decode_inst (
        .clk             (clk),
        .reset_n         (reset_n),
        .instruction     (if_id.instruction),
        .write_en        (mem_wb.control.reg_write),
        .write_id        (mem_wb.reg_rd_id),
        .write_data      (wb_result),
        .reg_rd_id       (decode_rd_id),
        .read_data1      (decode_data1),
        .read_data2      (decode_data2),
        .immediate_data  (decode_immediate),
        .control_signals (decode_control)
    );

    execute_stage execute_inst (
        .id_ex            (id_ex),
        .forward_a        (forward_a),
        .forward_b        (forward_b),
        .mem_forward_data (ex_mem.alu_data),
        .wb_forward_data  (wb_result),
        .hz               (hz.execute),
        .alu_data         (execute_alu_data),
        .memory_data      (execute_memory_data)
    );

    mem_stage #(.DATA_WORDS(DATA_WORDS)) mem_inst (
        .clk             (clk),
        .ex_mem          (ex_mem),
        .memory_data_out (memory_read_data)
    );

    hazard_unit hazard_inst (
        .if_id_rs1        (if_id.instruction.rs1),
        .if_id_rs2        (if_id.instruction.rs2),
        .id_ex            (id_ex),
        .ex_mem_rd        (ex_mem.reg_rd_id),
        .ex_mem_reg_write (ex_mem.control.reg_write),
        .mem_wb_rd        (mem_wb.reg_rd_id),
        .mem_wb_reg_write (mem_wb.control.reg_write),
        .forward_a        (forward_a),
        .forward_b        (forward_b),
        .hz               (hz.hazard)
    );

    assign wb_result = mem_wb.control.mem_read ? mem_wb.memory_data : mem_wb.alu_data;
    assign wb_valid  = mem_wb.control.reg_write;
    assign wb_rd     = mem_wb.reg_rd_id;
    assign wb_data   = wb_result;

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic                     clk,
    input  logic                     reset_n,
    input  cpu_pkg::instruction_type instruction,
    input  logic                     write_en,
    input  logic [4:0]               write_id,
    input  logic [31:0]              write_data,
    output logic [4:0]               reg_rd_id,
    output logic [31:0]              read_data1,
    output logic [31:0]              read_data2,
    output logic [31:0]              immediate_data,
    output cpu_pkg::control_type     control_signals
);
    import cpu_pkg::*;

    logic [31:0] regs [32];
    logic [31:0] raw;

    assign raw       = instruction;
    assign reg_rd_id = instruction.rd;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_id] <= write_data;
        end
    end

    // same-cycle writeback bypasses the array
    always_comb begin
        read_data1 = regs[instruction.rs1];
        read_data2 = regs[instruction.rs2];
        if (write_en && write_id == instruction.rs1) begin
            read_data1 = write_data;
        end
        if (write_en && write_id == instruction.rs2) begin
            read_data2 = write_data;
        end
        if (instruction.rs1 == 5'd0) begin
            read_data1 = '0;
        end
        if (instruction.rs2 == 5'd0) begin
            read_data2 = '0;
        end
    end

    always_comb begin
        control_signals = '0;
        immediate_data  = {{20{raw[31]}}, raw[31:20]};  // I-type
        case (instruction.opcode)
            OP_R: begin
                control_signals.reg_write = 1'b1;
                case ({instruction.funct7, instruction.funct3})
                    {7'b0000000, 3'b000}: control_signals.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: control_signals.alu_op = ALU_SUB;
                    {7'b0000000, 3'b100}: control_signals.alu_op = ALU_XOR;
                    {7'b0000000, 3'b110}: control_signals.alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: control_signals.alu_op = ALU_AND;
                    default:              control_signals.reg_write = 1'b0;
                endcase
            end
            OP_I: begin
                control_signals.alu_src   = (instruction.funct3 == 3'b000);
                control_signals.reg_write = (instruction.funct3 == 3'b000);  // addi only
            end
            OP_LOAD: begin
                control_signals.alu_src   = (instruction.funct3 == 3'b010);
                control_signals.mem_read  = (instruction.funct3 == 3'b010);
                control_signals.reg_write = (instruction.funct3 == 3'b010);
            end
            OP_STORE: begin
                immediate_data            = {{20{raw[31]}}, raw[31:25], raw[11:7]};
                control_signals.alu_src   = (instruction.funct3 == 3'b010);
                control_signals.mem_write = (instruction.funct3 == 3'b010);
            end
            OP_BRANCH: begin
                immediate_data = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
                control_signals.is_branch = (instruction.funct3[2:1] == 2'b00);  // beq, bne
                control_signals.branch_ne = instruction.funct3[0];
            end
            default: ;
        endcase
        if (instruction.rd == 5'd0) begin
            control_signals.reg_write = 1'b0;  // x0 stays zero
        end
    end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
    input  cpu_pkg::id_ex_type id_ex,
    input  cpu_pkg::forward_e  forward_a,
    input  cpu_pkg::forward_e  forward_b,
    input  logic [31:0]        mem_forward_data,
    input  logic [31:0]        wb_forward_data,
    hazard_if.execute          hz,
    output logic [31:0]        alu_data,
    output logic [31:0]        memory_data
);
    import cpu_pkg::*;

    logic [31:0] operand_a;
    logic [31:0] operand_b;
    logic [31:0] alu_b;

    function automatic logic [31:0] forward_mux(
        input forward_e    sel,
        input logic [31:0] reg_data,
        input logic [31:0] mem_data,
        input logic [31:0] wb_data
    );
        logic [31:0] value;
        case (sel)
            FWD_MEM: value = mem_data;
            FWD_WB:  value = wb_data;
            default: value = reg_data;
        endcase
        return value;
    endfunction

    assign operand_a = forward_mux(forward_a, id_ex.data1, mem_forward_data, wb_forward_data);
    assign operand_b = forward_mux(forward_b, id_ex.data2, mem_forward_data, wb_forward_data);

    assign alu_b       = id_ex.control.alu_src ? id_ex.immediate_data : operand_b;
    assign memory_data = operand_b;  // sw data

    always_comb begin
        case (id_ex.control.alu_op)
            ALU_SUB: alu_data = operand_a - alu_b;
            ALU_AND: alu_data = operand_a & alu_b;
            ALU_OR:  alu_data = operand_a | alu_b;
            ALU_XOR: alu_data = operand_a ^ alu_b;
            default: alu_data = operand_a + alu_b;
        endcase
    end

    assign hz.branch_taken  = id_ex.control.is_branch &&
                              ((operand_a == operand_b) != id_ex.control.branch_ne);
    assign hz.branch_target = id_ex.pc + id_ex.immediate_data;

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage (
    input  logic        clk,
    input  logic        reset_n,
    hazard_if.pipeline  hz,
    output logic [31:0] pc
);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc <= '0;
        end else if (hz.branch_taken) begin
            pc <= hz.branch_target;  // redirect wins over a stall
        end else if (hz.pc_write) begin
            pc <= pc + 32'd4;
        end
    end

endmodule

/* logic/hazard_unit.sv */
`timescale 1ns/1ns

module hazard_unit (
    input  logic [4:0]         if_id_rs1,
    input  logic [4:0]         if_id_rs2,
    input  cpu_pkg::id_ex_type id_ex,
    input  logic [4:0]         ex_mem_rd,
    input  logic               ex_mem_reg_write,
    input  logic [4:0]         mem_wb_rd,
    input  logic               mem_wb_reg_write,
    output cpu_pkg::forward_e  forward_a,
    output cpu_pkg::forward_e  forward_b,
    hazard_if.hazard           hz
);
    import cpu_pkg::*;

    logic load_use;

    // mem stage checked first so the newest value wins
    function automatic forward_e pick_source(
        input logic [4:0] rs,
        input logic [4:0] mem_rd,
        input logic       mem_write,
        input logic [4:0] wb_rd,
        input logic       wb_write
    );
        forward_e sel;
        if (mem_write && mem_rd == rs) begin
            sel = FWD_MEM;
        end else if (wb_write && wb_rd == rs) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_NONE;
        end
        return sel;
    endfunction

    assign forward_a = pick_source(id_ex.reg_rs1_id, ex_mem_rd, ex_mem_reg_write,
                                   mem_wb_rd, mem_wb_reg_write);
    assign forward_b = pick_source(id_ex.reg_rs2_id, ex_mem_rd, ex_mem_reg_write,
                                   mem_wb_rd, mem_wb_reg_write);

    assign load_use = id_ex.control.mem_read && id_ex.control.reg_write &&
                      (id_ex.reg_rd_id == if_id_rs1 || id_ex.reg_rd_id == if_id_rs2);

    assign hz.pc_write    = !load_use;
    assign hz.if_id_write = !load_use;
    assign hz.id_ex_flush = load_use;  // one bubble

endmodule

/* logic/mem_stage.sv */
`timescale 1ns/1ns

module mem_stage #(
    parameter int DATA_WORDS = 256
) (
    input  logic                clk,
    input  cpu_pkg::ex_mem_type ex_mem,
    output logic [31:0]         memory_data_out
);

    localparam int ADDR_W = $clog2(DATA_WORDS);

    logic [31:0]       data_mem [DATA_WORDS] = '{default: '0};  // zeroed at configuration
    logic [ADDR_W-1:0] word_index;

    assign word_index = ex_mem.alu_data[ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (ex_mem.control.mem_write) begin
            data_mem[word_index] <= ex_mem.memory_data;
        end
    end

    assign memory_data_out = data_mem[word_index];  // lw, async read

endmodule

/* logic/program_memory.sv */
`timescale 1ns/1ns

module program_memory #(
    parameter int   PROG_WORDS = 256,
    localparam int  ADDR_W     = $clog2(PROG_WORDS)
) (
    input  logic                     clk,
    input  logic [31:0]              byte_address,
    input  logic                     write_enable,
    input  logic [ADDR_W-1:0]        write_address,
    input  logic [31:0]              write_data,
    output cpu_pkg::instruction_type read_data
);

    logic [31:0] prog_mem [PROG_WORDS];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            prog_mem[write_address] <= write_data;
        end
    end

    assign read_data = prog_mem[byte_address[ADDR_W+1:2]];  // word index

endmodule

/* tb.f */
common/cpu_pkg.sv
common/hazard_if.sv
logic/fetch_stage.sv
logic/program_memory.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_stage.sv
logic/hazard_unit.sv
logic/cpu.sv
bench/cpu_sva.sv
bench/cpu_tb.sv
